// ==== logic/alu_pkg.sv ====
// shared ALU definitions
//   word and flag types
//   operation and width encodings
//   flag bit positions
//   width helpers: mask, sign bit, parity, flag byte packing
package alu_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [4:0] {
        OP_MOVE, OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP, OP_NEG,
        OP_AND, OP_OR, OP_XOR, OP_CPL,
        OP_RL, OP_RR, OP_RLC, OP_RRC, OP_SLA, OP_SRA, OP_SLL, OP_SRL,
        OP_SCF, OP_RCF, OP_CCF, OP_ZCF,
        OP_BIT, OP_SET, OP_RES, OP_CHG
    } alu_op_e;

    typedef enum logic [2:0] {
        W_BYTE = 3'b001,
        W_WORD = 3'b010,
        W_LONG = 3'b100
    } width_e;

    typedef logic [5:0] flag_bits_t;

    localparam int FLAG_C = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_V = 2;
    localparam int FLAG_H = 3;
    localparam int FLAG_Z = 4;
    localparam int FLAG_S = 5;

    function automatic word_t width_mask(input width_e w);
        case (w)
            W_BYTE:  return 32'h0000_00ff;
            W_WORD:  return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic sign_bit(input word_t x, input width_e w);
        case (w)
            W_BYTE:  return x[7];
            W_WORD:  return x[15];
            default: return x[31];
        endcase
    endfunction

    // long width uses the low 16 bits as well
    function automatic logic even_parity(input word_t x, input width_e w);
        return (w == W_BYTE) ? ~^x[7:0] : ~^x[15:0];
    endfunction

    function automatic logic [7:0] flags_byte(input flag_bits_t f);
        return {f[FLAG_S], f[FLAG_Z], 1'b0, f[FLAG_H], 1'b0, f[FLAG_V], f[FLAG_N], f[FLAG_C]};
    endfunction

endpackage

// ==== logic/alu_operand_stage.sv ====
// first pipeline stage of the ALU
//   source select between register and immediate
//   masking of both operands to the operation width
//   request registers
`timescale 1ns/1ns

module alu_operand_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  alu_pkg::alu_op_e op,
    input  alu_pkg::width_e  width,
    input  alu_pkg::word_t   op0,      // destination
    input  alu_pkg::word_t   op1,      // source
    input  alu_pkg::word_t   imm,
    input  logic            sel_imm,
    output logic            s1_valid,
    output alu_pkg::alu_op_e s1_op,
    output alu_pkg::width_e  s1_width,
    output alu_pkg::word_t   s1_a,
    output alu_pkg::word_t   s1_b
);
    import alu_pkg::*;

    word_t mask;
    word_t src;

    assign mask = width_mask(width);
    assign src  = sel_imm ? imm : op1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op    <= op;
        s1_width <= width;
        s1_a     <= op0 & mask;
        s1_b     <= src & mask; // imm or op1
    end

endmodule

// ==== logic/alu_arith.sv ====
// arithmetic unit, combinational
//   add and subtract with optional carry in
//   nibble and width carries, signed overflow
//   next flags and result write bit
`timescale 1ns/1ns

module alu_arith (
    input  alu_pkg::alu_op_e    s1_op,
    input  alu_pkg::width_e     s1_width,
    input  alu_pkg::word_t      s1_a,
    input  alu_pkg::word_t      s1_b,
    input  alu_pkg::flag_bits_t flags_q,
    output logic               arith_hit,
    output logic               arith_we,
    output alu_pkg::word_t      arith_result,
    output alu_pkg::flag_bits_t arith_flags
);
    import alu_pkg::*;

    logic        sub, cin, ci;
    logic        k0, k1, k2, k3, kw;
    logic        sx, sy;
    word_t       x, y, yy, m, r;
    logic [32:0] ext_x, ext_y, ext_r;

    always_comb begin
        arith_hit = 1'b0;
        arith_we  = 1'b0;
        sub       = 1'b0;
        cin       = 1'b0;
        case (s1_op)
            OP_ADD: begin
                arith_hit = 1'b1;
                arith_we  = 1'b1;
            end
            OP_ADC: begin
                arith_hit = 1'b1;
                arith_we  = 1'b1;
                cin       = flags_q[FLAG_C];
            end
            OP_SUB, OP_NEG: begin
                arith_hit = 1'b1;
                arith_we  = 1'b1;
                sub       = 1'b1;
            end
            OP_SBC: begin
                arith_hit = 1'b1;
                arith_we  = 1'b1;
                sub       = 1'b1;
                cin       = flags_q[FLAG_C];
            end
            OP_CP: begin
                arith_hit = 1'b1; // flags only
                sub       = 1'b1;
            end
            default: ;
        endcase
    end

    assign x  = (s1_op == OP_NEG) ? '0 : s1_a; // neg is 0 - dst
    assign y  = (s1_op == OP_NEG) ? s1_a : s1_b;
    assign m  = width_mask(s1_width);
    assign yy = sub ? ~y : y;
    assign ci = cin ^ sub;

    // nibble first, then the rest of the word
    assign {k0, r[3:0]}   = {1'b0, x[3:0]} + {1'b0, yy[3:0]} + 5'(ci);
    assign {k1, r[7:4]}   = {1'b0, x[7:4]} + {1'b0, yy[7:4]} + 5'(k0);
    assign {k2, r[15:8]}  = {1'b0, x[15:8]} + {1'b0, yy[15:8]} + 9'(k1);
    assign {k3, r[31:16]} = {1'b0, x[31:16]} + {1'b0, yy[31:16]} + 17'(k2);

    always_comb begin
        case (s1_width)
            W_BYTE:  kw = k1;
            W_WORD:  kw = k2;
            default: kw = k3;
        endcase
    end

    // sign extended copies for the overflow test
    assign sx    = sign_bit(x, s1_width);
    assign sy    = sign_bit(y, s1_width);
    assign ext_x = {sx, x | (sx ? ~m : '0)};
    assign ext_y = {sy, y | (sy ? ~m : '0)};
    assign ext_r = sub ? ext_x - ext_y - 33'(cin) : ext_x + ext_y + 33'(cin);

    assign arith_result = r;

    always_comb begin
        arith_flags[FLAG_S] = sign_bit(r, s1_width);
        arith_flags[FLAG_Z] = (r & m) == '0;
        arith_flags[FLAG_H] = k0 ^ sub; // borrow when subtracting
        arith_flags[FLAG_V] = ext_r[32] ^ sign_bit(r, s1_width);
        arith_flags[FLAG_N] = sub;
        arith_flags[FLAG_C] = kw ^ sub;
    end

endmodule

// ==== logic/alu_logic.sv ====
// logic unit, combinational
//   and, or, xor, complement, move
//   one-bit shifts and rotates at byte, word and long width
//   bit test, set, reset, change
//   carry flag operations
`timescale 1ns/1ns

module alu_logic (
    input  alu_pkg::alu_op_e    s1_op,
    input  alu_pkg::width_e     s1_width,
    input  alu_pkg::word_t      s1_a,
    input  alu_pkg::word_t      s1_b,
    input  alu_pkg::flag_bits_t flags_q,
    output alu_pkg::word_t      logic_result,
    output alu_pkg::flag_bits_t logic_flags,
    output logic               logic_we
);
    import alu_pkg::*;

    word_t      m, msb, onehot, res, rm;
    logic [4:0] idx;
    logic       in_bit, out_bit;

    assign m      = width_mask(s1_width);
    assign msb    = m ^ (m >> 1); // top bit of the width
    assign idx    = (s1_width == W_BYTE) ? {2'b00, s1_b[2:0]} : {1'b0, s1_b[3:0]};
    assign onehot = 32'd1 << idx;

    always_comb begin
        case (s1_op)
            OP_RL, OP_RR:   in_bit = flags_q[FLAG_C];
            OP_SRA, OP_RLC: in_bit = sign_bit(s1_a, s1_width);
            OP_RRC:         in_bit = s1_a[0];
            default:        in_bit = 1'b0;
        endcase
    end

    always_comb begin
        res      = s1_a;
        out_bit  = 1'b0;
        logic_we = 1'b1;
        case (s1_op)
            OP_MOVE: res = s1_b;
            OP_AND:  res = s1_a & s1_b;
            OP_OR:   res = s1_a | s1_b;
            OP_XOR:  res = s1_a ^ s1_b;
            OP_CPL:  res = ~s1_b;
            OP_RL, OP_RLC, OP_SLA, OP_SLL: begin
                res     = {s1_a[30:0], in_bit};
                out_bit = sign_bit(s1_a, s1_width);
            end
            OP_RR, OP_RRC, OP_SRA, OP_SRL: begin
                res     = (s1_a >> 1) | (in_bit ? msb : '0);
                out_bit = s1_a[0];
            end
            OP_SET:  res = s1_a | onehot;
            OP_RES:  res = s1_a & ~onehot;
            OP_CHG:  res = s1_a ^ onehot;
            default: logic_we = 1'b0; // flag-only ops
        endcase
    end

    assign rm           = res & m;
    assign logic_result = res;

    always_comb begin
        logic_flags = flags_q;
        case (s1_op)
            OP_AND, OP_OR, OP_XOR: begin
                logic_flags[FLAG_S] = sign_bit(rm, s1_width);
                logic_flags[FLAG_Z] = rm == '0;
                logic_flags[FLAG_V] = even_parity(rm, s1_width);
                logic_flags[FLAG_H] = s1_op == OP_AND;
                logic_flags[FLAG_N] = 1'b0;
                logic_flags[FLAG_C] = 1'b0;
            end
            OP_RL, OP_RR, OP_RLC, OP_RRC, OP_SLA, OP_SRA, OP_SLL, OP_SRL: begin
                logic_flags[FLAG_S] = sign_bit(rm, s1_width);
                logic_flags[FLAG_Z] = rm == '0;
                logic_flags[FLAG_V] = even_parity(rm, s1_width);
                logic_flags[FLAG_H] = 1'b0;
                logic_flags[FLAG_N] = 1'b0;
                logic_flags[FLAG_C] = out_bit;
            end
            OP_CPL: begin
                logic_flags[FLAG_H] = 1'b1;
                logic_flags[FLAG_N] = 1'b1;
            end
            OP_SCF, OP_RCF: begin
                logic_flags[FLAG_C] = s1_op == OP_SCF;
                logic_flags[FLAG_H] = 1'b0;
                logic_flags[FLAG_N] = 1'b0;
            end
            OP_CCF: begin
                logic_flags[FLAG_C] = ~flags_q[FLAG_C];
                logic_flags[FLAG_N] = 1'b0;
            end
            OP_ZCF: begin
                logic_flags[FLAG_C] = ~flags_q[FLAG_Z];
                logic_flags[FLAG_N] = 1'b0;
            end
            OP_BIT: begin
                logic_flags[FLAG_Z] = ~s1_a[idx];
                logic_flags[FLAG_H] = 1'b1;
                logic_flags[FLAG_N] = 1'b0;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/alu_writeback.sv ====
// second pipeline stage of the ALU
//   unit select by the arithmetic hit
//   flag register, result register and output strobes
//   architectural flag byte
`timescale 1ns/1ns

module alu_writeback (
    input  logic               clk,
    input  logic               rst,
    input  logic               s1_valid,
    input  alu_pkg::width_e     s1_width,
    input  logic               arith_hit,
    input  logic               arith_we,
    input  alu_pkg::word_t      arith_result,
    input  alu_pkg::flag_bits_t arith_flags,
    input  alu_pkg::word_t      logic_result,
    input  alu_pkg::flag_bits_t logic_flags,
    input  logic               logic_we,
    output alu_pkg::flag_bits_t flags_q,
    output logic               out_valid,
    output logic               result_we,
    output alu_pkg::word_t      dout,
    output logic [7:0]         flags
);
    import alu_pkg::*;

    word_t      nx_result;
    flag_bits_t nx_flags;
    logic       nx_we;

    assign nx_result = (arith_hit ? arith_result : logic_result) & width_mask(s1_width);
    assign nx_flags  = arith_hit ? arith_flags : logic_flags;
    assign nx_we     = arith_hit ? arith_we : logic_we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            result_we <= 1'b0;
            flags_q   <= '0;
            dout      <= '0;
        end else begin
            out_valid <= s1_valid;
            result_we <= s1_valid & nx_we;
            if (s1_valid) begin
                flags_q <= nx_flags; // seen by the next op in stage 1
            end
            if (s1_valid && nx_we) begin
                dout <= nx_result;
            end
        end
    end

    assign flags = flags_byte(flags_q);

endmodule

// ==== logic/tlcs900_alu.sv ====
// two-stage integer ALU top level
//   operand stage, arithmetic unit, logic unit, writeback stage
`timescale 1ns/1ns

module tlcs900_alu (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic            sel_imm,
    input  alu_pkg::alu_op_e op,
    input  alu_pkg::width_e  width,
    input  alu_pkg::word_t   op0,
    input  alu_pkg::word_t   op1,
    input  alu_pkg::word_t   imm,
    output logic            out_valid,
    output logic            result_we,
    output alu_pkg::word_t   dout,
    output logic [7:0]      flags
);
    import alu_pkg::*;

    logic       s1_valid;
    alu_op_e    s1_op;
    width_e     s1_width;
    word_t      s1_a, s1_b;
    flag_bits_t flags_q;
    logic       arith_hit, arith_we, logic_we;
    word_t      arith_result, logic_result;
    flag_bits_t arith_flags, logic_flags;

    alu_operand_stage u_operand (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .op       (op),
        .width    (width),
        .op0      (op0),
        .op1      (op1),
        .imm      (imm),
        .sel_imm  (sel_imm),
        .s1_valid (s1_valid),
        .s1_op    (s1_op),
        .s1_width (s1_width),
        .s1_a     (s1_a),
        .s1_b     (s1_b)
    );

    alu_arith u_arith (
        .s1_op        (s1_op),
        .s1_width     (s1_width),
        .s1_a         (s1_a),
        .s1_b         (s1_b),
        .flags_q      (flags_q),
        .arith_hit    (arith_hit),
        .arith_we     (arith_we),
        .arith_result (arith_result),
        .arith_flags  (arith_flags)
    );

    alu_logic u_logic (
        .s1_op        (s1_op),
        .s1_width     (s1_width),
        .s1_a         (s1_a),
        .s1_b         (s1_b),
        .flags_q      (flags_q),
        .logic_result (logic_result),
        .logic_flags  (logic_flags),
        .logic_we     (logic_we)
    );

    alu_writeback u_writeback (
        .clk          (clk),
        .rst          (rst),
        .s1_valid     (s1_valid),
        .s1_width     (s1_width),
        .arith_hit    (arith_hit),
        .arith_we     (arith_we),
        .arith_result (arith_result),
        .arith_flags  (arith_flags),
        .logic_result (logic_result),
        .logic_flags  (logic_flags),
        .logic_we     (logic_we),
        .flags_q      (flags_q),
        .out_valid    (out_valid),
        .result_we    (result_we),
        .dout         (dout),
        .flags        (flags)
    );

endmodule

// ==== tb/tlcs900_alu_chk.sv ====
// bound checker on the ALU outputs
//   strobe latency, write strobe, constant flag bits, known outputs
`timescale 1ns/1ns

module tlcs900_alu_chk (
    input logic           clk, rst, in_valid, out_valid, result_we,
    input alu_pkg::word_t dout,
    input logic [7:0]     flags
);
    int fails = 0;

    latency_2: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, 2)) else begin
        fails++;
        $error("out_valid is not in_valid delayed by 2 cycles");
    end

    we_in_valid: assert property (@(posedge clk) disable iff (rst)
        result_we |-> out_valid) else begin
        fails++;
        $error("result_we high without out_valid");
    end

    flag_zeros: assert property (@(posedge clk) disable iff (rst)
        flags[5] == 1'b0 && flags[3] == 1'b0) else begin
        fails++;
        $error("flag bit 5 or 3 is set");
    end

    known_out: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({out_valid, result_we, dout, flags})) else begin
        fails++;
        $error("unknown value on an output");
    end

endmodule

bind tlcs900_alu tlcs900_alu_chk chk (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result_we (result_we),
    .dout      (dout),
    .flags     (flags)
);

// ==== tb/alu_ref.svh ====
// reference model of one ALU operation
//   positions in the architectural flag byte
//   expected result record
//   arithmetic, logic, shift, bit and carry flag rules
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

localparam int BIT_S = 7;
localparam int BIT_Z = 6;
localparam int BIT_H = 4;
localparam int BIT_V = 2;
localparam int BIT_N = 1;
localparam int BIT_C = 0;

typedef struct packed {
    word_t      dout;
    logic [7:0] f;
    logic       we;
} exp_t;

// d and f are the state left by the previous operation
function automatic exp_t alu_ref(input alu_op_e op, input width_e w, input word_t dst,
                                 input word_t src, input logic [7:0] f, input word_t d);
    exp_t        e;
    int          n;
    word_t       m, a, b, r;
    logic [32:0] full;
    logic [4:0]  idx;
    logic        c, cin, sub, left, shin, shout, szp;
    n    = (w == W_BYTE) ? 8 : (w == W_WORD) ? 16 : 32;
    m    = 32'hffff_ffff >> (32 - n);
    a    = dst & m;
    b    = src & m;
    c    = f[BIT_C];
    idx  = (w == W_BYTE) ? {2'b00, b[2:0]} : {1'b0, b[3:0]};
    r    = a;
    szp  = 1'b0;
    e.f  = f;
    e.we = !(op inside {OP_CP, OP_SCF, OP_RCF, OP_CCF, OP_ZCF, OP_BIT});
    case (op)
        OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP, OP_NEG: begin
            sub = !(op inside {OP_ADD, OP_ADC});
            cin = (op inside {OP_ADC, OP_SBC}) ? c : 1'b0;
            if (op == OP_NEG) begin
                b = a;
                a = '0;
            end
            full = sub ? {1'b0, a} - {1'b0, b} - 33'(cin) : {1'b0, a} + {1'b0, b} + 33'(cin);
            r = full[31:0] & m;
            e.f[BIT_S] = r[n-1];
            e.f[BIT_Z] = r == '0;
            e.f[BIT_H] = sub ? {1'b0, a[3:0]} < {1'b0, b[3:0]} + 5'(cin)
                             : {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin) > 5'd15;
            e.f[BIT_V] = (sub ? a[n-1] != b[n-1] : a[n-1] == b[n-1]) && r[n-1] != a[n-1];
            e.f[BIT_N] = sub;
            e.f[BIT_C] = full[n]; // carry or borrow at the top
        end
        OP_MOVE: r = b;
        OP_AND, OP_OR, OP_XOR: begin
            r   = (op == OP_AND) ? a & b : (op == OP_OR) ? a | b : a ^ b;
            szp = 1'b1;
            e.f[BIT_H] = op == OP_AND;
            e.f[BIT_N] = 1'b0;
            e.f[BIT_C] = 1'b0;
        end
        OP_CPL: begin
            r = ~b & m;
            e.f[BIT_H] = 1'b1;
            e.f[BIT_N] = 1'b1;
        end
        OP_RL, OP_RLC, OP_SLA, OP_SLL, OP_RR, OP_RRC, OP_SRA, OP_SRL: begin
            left  = op inside {OP_RL, OP_RLC, OP_SLA, OP_SLL};
            shout = left ? a[n-1] : a[0];
            case (op)
                OP_RL, OP_RR:   shin = c;
                OP_RLC, OP_RRC: shin = shout;
                OP_SRA:         shin = a[n-1];
                default:        shin = 1'b0;
            endcase
            r   = left ? ((a << 1) | word_t'(shin)) & m : (a >> 1) | (word_t'(shin) << (n - 1));
            szp = 1'b1;
            e.f[BIT_H] = 1'b0;
            e.f[BIT_N] = 1'b0;
            e.f[BIT_C] = shout;
        end
        OP_SCF, OP_RCF: begin
            e.f[BIT_C] = op == OP_SCF;
            e.f[BIT_H] = 1'b0;
            e.f[BIT_N] = 1'b0;
        end
        OP_CCF, OP_ZCF: begin
            e.f[BIT_C] = (op == OP_CCF) ? !c : !f[BIT_Z];
            e.f[BIT_N] = 1'b0;
        end
        OP_BIT: begin
            e.f[BIT_Z] = !a[idx];
            e.f[BIT_H] = 1'b1;
            e.f[BIT_N] = 1'b0;
        end
        OP_SET:  r = a | (32'd1 << idx);
        OP_RES:  r = a & ~(32'd1 << idx);
        OP_CHG:  r = a ^ (32'd1 << idx);
        default: ;
    endcase
    if (szp) begin
        e.f[BIT_S] = r[n-1];
        e.f[BIT_Z] = r == '0;
        e.f[BIT_V] = (w == W_BYTE) ? ~^r[7:0] : ~^r[15:0]; // parity
    end
    e.dout = e.we ? r : d;
    return e;
endfunction

`endif

// ==== tb/tlcs900_alu_tb.sv ====
// testbench for the two-stage integer ALU
//   clock, reset and random stimulus per operation group
//   reference queue filled at issue, comparing process on the outputs
//   watchdog and closing report
`timescale 1ns/1ns

module tlcs900_alu_tb;
    import alu_pkg::*;
    `include "alu_ref.svh"

    localparam int N_GROUP  = 150;
    localparam int N_SHIFT  = 8 * 3 * 4 * 2;
    localparam int N_STREAM = 300;
    localparam int N_CYCLES = 2 * 3 * N_GROUP + 20 + N_SHIFT + N_STREAM * 29 / 25 + 24;

    logic       clk, rst, in_valid, sel_imm, out_valid, result_we;
    alu_op_e    op;
    width_e     width;
    word_t      op0, op1, imm, dout;
    logic [7:0] flags;

    int         seed = 34;
    int         val_err = 0;
    int         seq_err = 0;
    int         end_err = 0;
    exp_t       exp_q[$];
    logic [7:0] model_f = '0; // state after sequential execution
    word_t      model_d = '0;

    tlcs900_alu dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((N_CYCLES + 40) * 100);
        $display("watchdog expired before the stimulus finished");
        $display("Test FAILED");
        $finish;
    end

    function automatic width_e any_width();
        return width_e'(3'b001 << ($unsigned($random(seed)) % 3));
    endfunction

    task automatic issue(input alu_op_e o, input width_e w);
        @(negedge clk);
        in_valid = 1'b1;
        op       = o;
        width    = w;
        op0      = $random(seed);
        op1      = ($random(seed) % 4 == 0) ? op0 : $random(seed); // equal now and then
        imm      = $random(seed);
        sel_imm  = $random(seed) % 3 == 0;
    endtask

    task automatic random_ops(input int lo, input int span, input int n, input bit gaps);
        repeat (n) begin
            issue(alu_op_e'(lo + $unsigned($random(seed)) % span), any_width());
            if (gaps && $random(seed) % 2 == 0) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        exp_t e;
        if (!rst && in_valid) begin
            e = alu_ref(op, width, op0, sel_imm ? imm : op1, model_f, model_d);
            exp_q.push_back(e);
            model_f = e.f;
            model_d = e.dout;
        end
    end

    always @(negedge clk) begin
        exp_t e;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid at %0t ns with no request in flight", $time);
                seq_err++;
            end else begin
                e = exp_q.pop_front();
                assert (dout == e.dout && flags == e.f && result_we == e.we) else begin
                    $display("error at %0t ns: expected dout %h flags %h we %b, got %h %h %b",
                             $time, e.dout, e.f, e.we, dout, flags, result_we);
                    val_err++;
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        sel_imm  = 1'b0;
        op       = OP_MOVE;
        width    = W_BYTE;
        op0      = '0;
        op1      = '0;
        imm      = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!out_valid && !result_we && dout == '0 && flags == 8'h00) else begin
            $display("error at %0t ns: outputs not zero after reset", $time);
            end_err++;
        end
        random_ops(OP_ADD, 6, N_GROUP, 1'b1); // add through neg
        random_ops(OP_AND, 4, N_GROUP, 1'b1); // and through cpl
        repeat (20) issue(OP_MOVE, any_width());
        for (int s = OP_RL; s <= OP_SRL; s++) begin
            for (int k = 0; k < 3; k++) begin
                repeat (4) begin
                    issue(($random(seed) % 2 == 0) ? OP_SCF : OP_RCF, W_LONG);
                    issue(alu_op_e'(s), width_e'(3'b001 << k));
                end
            end
        end
        random_ops(OP_SCF, 8, N_GROUP, 1'b1); // carry flag and bit ops
        for (int i = 0; i < N_STREAM; i++) begin
            if (i % 25 == 0) begin
                issue(OP_ADD, W_BYTE);
                issue(OP_ADC, W_BYTE);
                issue(OP_CCF, W_BYTE);
                issue(OP_CCF, W_BYTE);
            end
            issue(alu_op_e'($unsigned($random(seed)) % 27), any_width());
        end
        @(negedge clk);
        in_valid = 1'b0;
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out of the DUT", exp_q.size());
            end_err++;
        end
        $display("errors: %0d result, %0d sequence, %0d end of run, %0d assertion",
                 val_err, seq_err, end_err, dut.chk.fails);
        if (val_err + seq_err + end_err + dut.chk.fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tlcs900_alu.f ====
+incdir+tb
logic/alu_pkg.sv
logic/alu_operand_stage.sv
logic/alu_arith.sv
logic/alu_logic.sv
logic/alu_writeback.sv
logic/tlcs900_alu.sv
tb/tlcs900_alu_chk.sv
tb/tlcs900_alu_tb.sv

// ==== Makefile ====
TOP = tlcs900_alu_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tlcs900_alu.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "Test FAILED" $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
